// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rename_map_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Result: PASSED
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
logic/rat_pkg.sv
logic/rat_bank_ram.sv
logic/rat_lvt_ram.sv
logic/free_list.sv
logic/checkpoint_ctrl.sv
logic/rename_port.sv
logic/rename_map_top.sv
verification/rename_map_checker.sv
verification/rename_map_tb.sv

// ==== logic/checkpoint_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module checkpoint_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic ckpt_save,
	input  logic ckpt_restore,
	input  rat_pkg::ckpt_ndx_t ckpt_restore_id,
	output logic busy,
	output rat_pkg::ckpt_ndx_t ckpt_cur,
	output logic sweep_active,
	output logic sweep_copy,
	output rat_pkg::aregno_t sweep_areg,
	output rat_pkg::ckpt_ndx_t sweep_dst_ckpt
);

	import rat_pkg::*;

	ckpt_state_t state;
	// Register being written by the sweep
	aregno_t cnt;
	// Set on the final register of a sweep
	logic last_reg;
	// Checkpoint that follows the current one, wrapping at the end
	ckpt_ndx_t ckpt_next;

	assign last_reg = (cnt == aregno_t'(NUM_AREG - 1));
	assign ckpt_next = ckpt_cur + ckpt_ndx_t'(1);

	// ==================================================
	// State machine
	// ==================================================

	// Reset starts the identity sweep into checkpoint 0
	// A restore while idle takes effect at the next edge and wins over a save
	// A save starts a copy that walks every register once
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CK_SWEEP;
			cnt <= '0;
			ckpt_cur <= '0;
		end
		else begin
			case (state)
				CK_SWEEP: begin
					cnt <= cnt + aregno_t'(1);
					if (last_reg)
						state <= CK_IDLE;
				end
				CK_IDLE: begin
					cnt <= '0;
					if (ckpt_restore)
						ckpt_cur <= ckpt_restore_id;
					else if (ckpt_save)
						state <= CK_COPY;
				end
				CK_COPY: begin
					cnt <= cnt + aregno_t'(1);
					// The copy is complete, so the new checkpoint becomes current
					if (last_reg) begin
						ckpt_cur <= ckpt_next;
						state <= CK_IDLE;
					end
				end
				default: begin
					state <= CK_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Sweep outputs
	// ==================================================

	// Any state other than idle owns the table ports
	assign sweep_active = (state != CK_IDLE);
	assign busy = sweep_active;

	// The copy writes read data, the reset sweep writes identity values
	assign sweep_copy = (state == CK_COPY);
	assign sweep_areg = cnt;

	// Reset fills checkpoint 0 and a save fills the next checkpoint
	assign sweep_dst_ckpt = sweep_copy ? ckpt_next : ckpt_ndx_t'(0);

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list (
	input  logic clk,
	input  logic rst,
	input  logic [1:0] alloc_cnt,
	output rat_pkg::pregno_t alloc_preg0,
	output rat_pkg::pregno_t alloc_preg1,
	output logic [$clog2(rat_pkg::NUM_PREG):0] avail,
	input  logic rel_valid,
	input  rat_pkg::pregno_t rel_preg
);

	import rat_pkg::*;

	localparam int PTR_W = $clog2(NUM_PREG);
	localparam int CNT_W = PTR_W + 1;

	// Queue storage has room for every physical register
	pregno_t fifo [NUM_PREG];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;

	// Releases are staged for one cycle before they join the queue
	logic rel_pend;
	pregno_t rel_pend_preg;

	// The two oldest free registers are always on show
	// The pointer wraps naturally at the queue size
	assign alloc_preg0 = fifo[head];
	assign alloc_preg1 = fifo[head + PTR_W'(1)];
	assign avail = count;

	// Capture the release strobe and register number
	always_ff @(posedge clk) begin
		if (rst)
			rel_pend <= 1'b0;
		else
			rel_pend <= rel_valid;
	end

	always_ff @(posedge clk) begin
		if (rel_valid)
			rel_pend_preg <= rel_preg;
	end

	// Queue pointers, count and contents
	// At reset the architectural registers own physical 0 to 31
	// so the queue is loaded with 32 to 63 in ascending order
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_AREG; i++) begin
				fifo[i] <= pregno_t'(NUM_AREG + i);
			end
			head <= '0;
			tail <= PTR_W'(NUM_AREG);
			count <= CNT_W'(NUM_AREG);
		end
		else begin
			// Pop the entries the rename stage took this cycle
			head <= head + PTR_W'(alloc_cnt);
			// Push the staged release at the tail
			if (rel_pend) begin
				fifo[tail] <= rel_pend_preg;
				tail <= tail + PTR_W'(1);
			end
			count <= count + CNT_W'(rel_pend) - CNT_W'(alloc_cnt);
		end
	end

endmodule

`default_nettype wire

// ==== logic/rat_bank_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module rat_bank_ram (
	input  logic clk,
	input  logic we,
	input  rat_pkg::rat_addr_t waddr,
	input  rat_pkg::pregno_t wdata,
	input  rat_pkg::rat_addr_t [rat_pkg::RPORTS-1:0] raddr,
	output rat_pkg::pregno_t [rat_pkg::RPORTS-1:0] rdata
);

	import rat_pkg::*;

	// Storage for every checkpoint and register of one write port
	pregno_t mem [RAT_DEPTH];

	// Single write port at the rising edge
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Every read port looks straight into the array
	// This maps onto distributed RAM with one copy per read port
	always_comb begin
		for (int r = 0; r < RPORTS; r++) begin
			rdata[r] = mem[raddr[r]];
		end
	end

endmodule

`default_nettype wire

// ==== logic/rat_lvt_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module rat_lvt_ram (
	input  logic clk,
	input  logic rst,
	input  logic [rat_pkg::WPORTS-1:0] wr,
	input  rat_pkg::ckpt_ndx_t wr_ckpt,
	input  rat_pkg::aregno_t [rat_pkg::WPORTS-1:0] wa,
	input  rat_pkg::pregno_t [rat_pkg::WPORTS-1:0] wdata,
	input  rat_pkg::rat_addr_t [rat_pkg::RPORTS-1:0] ra,
	input  logic [rat_pkg::RPORTS-1:0][rat_pkg::WPORTS-1:0] byp_mask,
	output rat_pkg::pregno_t [rat_pkg::RPORTS-1:0] rdata
);

	import rat_pkg::*;

	// ==================================================
	// Write side
	// ==================================================

	// Full table address of each write port
	rat_addr_t [WPORTS-1:0] waddr;

	always_comb begin
		for (int w = 0; w < WPORTS; w++) begin
			waddr[w] = {wr_ckpt, wa[w]};
		end
	end

	// Each bank sees every read address but only its own write port
	pregno_t [RPORTS-1:0] bank_rdata [WPORTS];

	for (genvar gw = 0; gw < WPORTS; gw++) begin : g_bank
		rat_bank_ram i_bank (
			.clk   (clk),
			.we    (wr[gw]),
			.waddr (waddr[gw]),
			.wdata (wdata[gw]),
			.raddr (ra),
			.rdata (bank_rdata[gw])
		);
	end

	// ==================================================
	// Live value table
	// ==================================================

	// One selector per table entry
	lvt_sel_t lvt [RAT_DEPTH];

	// The LVT entry remembers which port wrote the address last
	// Ports are scanned upward, so on a collision the higher port is recorded
	// Its bank holds the same address with the newer value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int n = 0; n < RAT_DEPTH; n++) begin
				lvt[n] <= '0;
			end
		end
		else begin
			for (int w = 0; w < WPORTS; w++) begin
				if (wr[w])
					lvt[waddr[w]] <= lvt_sel_t'(w);
			end
		end
	end

	// ==================================================
	// Read side
	// ==================================================

	// Start from the bank the LVT names for the address
	// A same-cycle write then overrides it when the mask lets it through
	// The highest matching write port is checked last and so takes priority
	always_comb begin
		for (int r = 0; r < RPORTS; r++) begin
			rdata[r] = bank_rdata[lvt[ra[r]]][r];
			for (int w = 0; w < WPORTS; w++) begin
				if (byp_mask[r][w] && wr[w] && ra[r] == waddr[w])
					rdata[r] = wdata[w];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/rat_pkg.sv ====
`default_nettype none

package rat_pkg;

	// ==================================================
	// Sizes of the rename map
	// ==================================================

	// Architectural registers seen by the instruction set
	localparam int NUM_AREG = 32;
	// Physical registers in the register file
	localparam int NUM_PREG = 64;
	// Checkpoints held by the alias table
	localparam int NUM_CKPT = 4;
	// One write port per instruction in a rename group
	localparam int WPORTS = 2;
	// Two source reads per instruction
	localparam int RPORTS = 4;
	// Entries in each bank and in the LVT
	localparam int RAT_DEPTH = NUM_CKPT * NUM_AREG;

	// ==================================================
	// Types
	// ==================================================

	typedef logic [$clog2(NUM_AREG)-1:0] aregno_t;
	typedef logic [$clog2(NUM_PREG)-1:0] pregno_t;
	typedef logic [$clog2(NUM_CKPT)-1:0] ckpt_ndx_t;
	// Checkpoint index in the upper bits, register number below it
	typedef logic [$clog2(RAT_DEPTH)-1:0] rat_addr_t;
	// Names the bank that holds the newest value of an entry
	typedef logic [$clog2(WPORTS)-1:0] lvt_sel_t;

	// Sweep at reset, idle, or copy of one checkpoint into the next
	typedef enum logic [1:0] {CK_SWEEP, CK_IDLE, CK_COPY} ckpt_state_t;

endpackage

`default_nettype wire

// ==== logic/rename_map_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_map_top (
	input  logic clk,
	input  logic rst,
	input  logic ren_valid,
	input  rat_pkg::aregno_t ren_src_a0,
	input  rat_pkg::aregno_t ren_src_b0,
	input  rat_pkg::aregno_t ren_src_a1,
	input  rat_pkg::aregno_t ren_src_b1,
	input  rat_pkg::aregno_t ren_dst0,
	input  rat_pkg::aregno_t ren_dst1,
	input  logic ren_has_dst0,
	input  logic ren_has_dst1,
	input  logic rel_valid,
	input  rat_pkg::pregno_t rel_preg,
	input  logic ckpt_save,
	input  logic ckpt_restore,
	input  rat_pkg::ckpt_ndx_t ckpt_restore_id,
	output logic ren_accept,
	output rat_pkg::pregno_t ren_psrc_a0,
	output rat_pkg::pregno_t ren_psrc_b0,
	output rat_pkg::pregno_t ren_psrc_a1,
	output rat_pkg::pregno_t ren_psrc_b1,
	output rat_pkg::pregno_t ren_pdst0,
	output rat_pkg::pregno_t ren_pdst1,
	output logic busy,
	output rat_pkg::ckpt_ndx_t ckpt_cur
);

	import rat_pkg::*;

	// Table ports
	logic [WPORTS-1:0] wr;
	ckpt_ndx_t wr_ckpt;
	aregno_t [WPORTS-1:0] wa;
	pregno_t [WPORTS-1:0] wdata;
	rat_addr_t [RPORTS-1:0] ra;
	logic [RPORTS-1:0][WPORTS-1:0] byp_mask;
	pregno_t [RPORTS-1:0] rdata;

	// Free list
	logic [1:0] alloc_cnt;
	pregno_t alloc_preg0;
	pregno_t alloc_preg1;
	logic [$clog2(NUM_PREG):0] avail;

	// Sweep control
	logic sweep_active;
	logic sweep_copy;
	aregno_t sweep_areg;
	ckpt_ndx_t sweep_dst_ckpt;

	rat_lvt_ram i_rat (
		.clk (clk), .rst (rst), .wr (wr), .wr_ckpt (wr_ckpt), .wa (wa),
		.wdata (wdata), .ra (ra), .byp_mask (byp_mask), .rdata (rdata)
	);

	free_list i_free_list (
		.clk (clk), .rst (rst), .alloc_cnt (alloc_cnt), .alloc_preg0 (alloc_preg0),
		.alloc_preg1 (alloc_preg1), .avail (avail), .rel_valid (rel_valid),
		.rel_preg (rel_preg)
	);

	checkpoint_ctrl i_checkpoint_ctrl (
		.clk (clk), .rst (rst), .ckpt_save (ckpt_save), .ckpt_restore (ckpt_restore),
		.ckpt_restore_id (ckpt_restore_id), .busy (busy), .ckpt_cur (ckpt_cur),
		.sweep_active (sweep_active), .sweep_copy (sweep_copy),
		.sweep_areg (sweep_areg), .sweep_dst_ckpt (sweep_dst_ckpt)
	);

	rename_port i_rename_port (
		.ren_valid (ren_valid), .ren_src_a0 (ren_src_a0), .ren_src_b0 (ren_src_b0),
		.ren_src_a1 (ren_src_a1), .ren_src_b1 (ren_src_b1), .ren_dst0 (ren_dst0),
		.ren_dst1 (ren_dst1), .ren_has_dst0 (ren_has_dst0), .ren_has_dst1 (ren_has_dst1),
		.ren_accept (ren_accept), .ren_psrc_a0 (ren_psrc_a0), .ren_psrc_b0 (ren_psrc_b0),
		.ren_psrc_a1 (ren_psrc_a1), .ren_psrc_b1 (ren_psrc_b1), .ren_pdst0 (ren_pdst0),
		.ren_pdst1 (ren_pdst1), .ckpt_cur (ckpt_cur), .sweep_active (sweep_active),
		.sweep_copy (sweep_copy), .sweep_areg (sweep_areg),
		.sweep_dst_ckpt (sweep_dst_ckpt), .alloc_preg0 (alloc_preg0),
		.alloc_preg1 (alloc_preg1), .avail (avail), .alloc_cnt (alloc_cnt), .wr (wr),
		.wr_ckpt (wr_ckpt), .wa (wa), .wdata (wdata), .ra (ra), .byp_mask (byp_mask),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

// ==== logic/rename_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_port (
	input  logic ren_valid,
	input  rat_pkg::aregno_t ren_src_a0,
	input  rat_pkg::aregno_t ren_src_b0,
	input  rat_pkg::aregno_t ren_src_a1,
	input  rat_pkg::aregno_t ren_src_b1,
	input  rat_pkg::aregno_t ren_dst0,
	input  rat_pkg::aregno_t ren_dst1,
	input  logic ren_has_dst0,
	input  logic ren_has_dst1,
	output logic ren_accept,
	output rat_pkg::pregno_t ren_psrc_a0,
	output rat_pkg::pregno_t ren_psrc_b0,
	output rat_pkg::pregno_t ren_psrc_a1,
	output rat_pkg::pregno_t ren_psrc_b1,
	output rat_pkg::pregno_t ren_pdst0,
	output rat_pkg::pregno_t ren_pdst1,
	input  rat_pkg::ckpt_ndx_t ckpt_cur,
	input  logic sweep_active,
	input  logic sweep_copy,
	input  rat_pkg::aregno_t sweep_areg,
	input  rat_pkg::ckpt_ndx_t sweep_dst_ckpt,
	input  rat_pkg::pregno_t alloc_preg0,
	input  rat_pkg::pregno_t alloc_preg1,
	input  logic [$clog2(rat_pkg::NUM_PREG):0] avail,
	output logic [1:0] alloc_cnt,
	output logic [rat_pkg::WPORTS-1:0] wr,
	output rat_pkg::ckpt_ndx_t wr_ckpt,
	output rat_pkg::aregno_t [rat_pkg::WPORTS-1:0] wa,
	output rat_pkg::pregno_t [rat_pkg::WPORTS-1:0] wdata,
	output rat_pkg::rat_addr_t [rat_pkg::RPORTS-1:0] ra,
	output logic [rat_pkg::RPORTS-1:0][rat_pkg::WPORTS-1:0] byp_mask,
	input  rat_pkg::pregno_t [rat_pkg::RPORTS-1:0] rdata
);

	import rat_pkg::*;

	// Destinations the group needs from the free list
	logic [1:0] need_cnt;

	assign need_cnt = 2'(ren_has_dst0) + 2'(ren_has_dst1);

	// A group goes through only when the table is free and enough registers wait
	assign ren_accept = ren_valid && !sweep_active && (avail >= 7'(need_cnt));
	assign alloc_cnt = ren_accept ? need_cnt : 2'd0;

	// The first writer takes the head entry of the free list
	assign ren_pdst0 = alloc_preg0;
	assign ren_pdst1 = ren_has_dst0 ? alloc_preg1 : alloc_preg0;

	assign ren_psrc_a0 = rdata[0];
	assign ren_psrc_b0 = rdata[1];
	assign ren_psrc_a1 = rdata[2];
	assign ren_psrc_b1 = rdata[3];

	// Only the sources of instruction 1 look at write port 0
	assign byp_mask = {2'b01, 2'b01, 2'b00, 2'b00};

	// Table port steering
	always_comb begin
		ra[0] = {ckpt_cur, ren_src_a0};
		ra[1] = {ckpt_cur, ren_src_b0};
		ra[2] = {ckpt_cur, ren_src_a1};
		ra[3] = {ckpt_cur, ren_src_b1};
		wr = {ren_accept && ren_has_dst1, ren_accept && ren_has_dst0};
		wr_ckpt = ckpt_cur;
		wa = {ren_dst1, ren_dst0};
		wdata = {ren_pdst1, ren_pdst0};
		// The sweep borrows read port 0 and write port 0
		if (sweep_active) begin
			ra[0] = {ckpt_cur, sweep_areg};
			wr = 2'b01;
			wr_ckpt = sweep_dst_ckpt;
			wa[0] = sweep_areg;
			wdata[0] = sweep_copy ? rdata[0] : pregno_t'(sweep_areg);
		end
	end

endmodule

`default_nettype wire

// ==== verification/rename_map_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_map_checker (
	input  logic clk,
	input  logic rst,
	input  logic busy,
	input  logic ren_accept,
	input  logic ren_has_dst0,
	input  logic ren_has_dst1,
	input  rat_pkg::pregno_t ren_pdst0,
	input  rat_pkg::pregno_t ren_pdst1,
	input  logic rel_valid,
	input  logic [$clog2(rat_pkg::NUM_PREG):0] avail
);

	import rat_pkg::*;

	// ==================================================
	// Reset and rename protocol
	// ==================================================

	// The identity sweep owns the table right after every reset edge
	assert property (@(posedge clk) rst |=> busy)
		else $error("busy was low in the cycle after a reset edge");

	// A group must never slip through while the sweep or a copy runs
	assert property (@(posedge clk) disable iff (rst) ren_accept |-> !busy)
		else $error("rename group accepted while the table was busy");

	// Two destinations of one group always get two different registers
	assert property (@(posedge clk) disable iff (rst)
		(ren_accept && ren_has_dst0 && ren_has_dst1) |-> (ren_pdst0 != ren_pdst1))
		else $error("both destinations of a group got the same physical register");

	// ==================================================
	// Free list capacity
	// ==================================================

	// A full queue has no room for one more released register
	assert property (@(posedge clk) disable iff (rst) rel_valid |-> (avail != 7'(NUM_PREG)))
		else $error("release arrived while the free list was already full");

endmodule

bind rename_map_top rename_map_checker i_rename_map_checker (
	.clk          (clk),
	.rst          (rst),
	.busy         (busy),
	.ren_accept   (ren_accept),
	.ren_has_dst0 (ren_has_dst0),
	.ren_has_dst1 (ren_has_dst1),
	.ren_pdst0    (ren_pdst0),
	.ren_pdst1    (ren_pdst1),
	.rel_valid    (rel_valid),
	.avail        (avail)
);

`default_nettype wire

// ==== verification/rename_map_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_map_tb;

	import rat_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RAND_CYCLES = 300;
	// Reset, the sweep, one copy and the directed groups, with room to spare
	localparam int TEST_CYCLES = 2 + 6 * (NUM_AREG + 2) + RAND_CYCLES;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

	logic clk, rst, ren_valid, ren_has_dst0, ren_has_dst1, rel_valid;
	logic ckpt_save, ckpt_restore, ren_accept, busy;
	aregno_t ren_src_a0, ren_src_b0, ren_src_a1, ren_src_b1, ren_dst0, ren_dst1;
	pregno_t rel_preg, ren_psrc_a0, ren_psrc_b0, ren_psrc_a1, ren_psrc_b1;
	pregno_t ren_pdst0, ren_pdst1;
	ckpt_ndx_t ckpt_restore_id, ckpt_cur;

	// ==================================================
	// Reference model state
	// ==================================================

	pregno_t map_model [NUM_CKPT][NUM_AREG];
	logic [NUM_CKPT-1:0] ckpt_valid;
	pregno_t free_q [$];
	// Allocated registers in allocation order, released oldest first
	pregno_t inflight_q [$];
	int m_busy_cnt;
	logic m_copy;
	ckpt_ndx_t m_ckpt;
	logic rel_pend;
	pregno_t rel_pend_preg;
	// Expected outputs for the current cycle, set on the falling edge
	logic exp_accept, exp_busy;
	ckpt_ndx_t exp_ckpt;
	pregno_t exp_psrc_a0, exp_psrc_b0, exp_psrc_a1, exp_psrc_b1, exp_pdst0, exp_pdst1;
	logic [31:0] lfsr_state;
	string test_name;

	rename_map_top i_rename_map_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Result: FAILED");
		$fatal(1, "simulation timeout");
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// One LFSR step for every bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return val;
	endfunction

	// Instruction 1 sources see the new register of instruction 0 in the same cycle
	function automatic void predict();
		int need;
		pregno_t head0;
		pregno_t head1;
		need = int'(ren_has_dst0) + int'(ren_has_dst1);
		head0 = (free_q.size() > 0) ? free_q[0] : '0;
		head1 = (free_q.size() > 1) ? free_q[1] : '0;
		exp_busy = (m_busy_cnt != 0);
		exp_ckpt = m_ckpt;
		exp_accept = ren_valid && !exp_busy && (free_q.size() >= need);
		exp_pdst0 = head0;
		exp_pdst1 = ren_has_dst0 ? head1 : head0;
		exp_psrc_a0 = map_model[m_ckpt][ren_src_a0];
		exp_psrc_b0 = map_model[m_ckpt][ren_src_b0];
		exp_psrc_a1 = (ren_has_dst0 && ren_src_a1 == ren_dst0) ? head0
			: map_model[m_ckpt][ren_src_a1];
		exp_psrc_b1 = (ren_has_dst0 && ren_src_b1 == ren_dst0) ? head0
			: map_model[m_ckpt][ren_src_b1];
	endfunction

	// Model update at the rising edge, mirroring the rename and checkpoint rules
	always @(posedge clk) begin : commit
		ckpt_ndx_t nxt;
		nxt = m_ckpt + ckpt_ndx_t'(1);
		if (rst) begin
			free_q.delete();
			inflight_q.delete();
			for (int k = 0; k < NUM_AREG; k++) begin
				map_model[0][k] = pregno_t'(k);
				free_q.push_back(pregno_t'(NUM_AREG + k));
			end
			ckpt_valid = 4'b0001;
			m_busy_cnt = NUM_AREG;
			m_copy = 1'b0;
			m_ckpt = '0;
			rel_pend = 1'b0;
		end
		else begin
			// Writes go to the current checkpoint before any restore moves it
			if (exp_accept && ren_has_dst0) begin
				map_model[m_ckpt][ren_dst0] = exp_pdst0;
				inflight_q.push_back(exp_pdst0);
				void'(free_q.pop_front());
			end
			if (exp_accept && ren_has_dst1) begin
				map_model[m_ckpt][ren_dst1] = exp_pdst1;
				inflight_q.push_back(exp_pdst1);
				void'(free_q.pop_front());
			end
			if (rel_pend)
				free_q.push_back(rel_pend_preg);
			if (rel_valid)
				void'(inflight_q.pop_front());
			rel_pend = rel_valid;
			rel_pend_preg = rel_preg;
			if (m_busy_cnt != 0) begin
				m_busy_cnt = m_busy_cnt - 1;
				// The whole copy lands when the last register is done
				if (m_busy_cnt == 0 && m_copy) begin
					map_model[nxt] = map_model[m_ckpt];
					ckpt_valid[nxt] = 1'b1;
					m_ckpt = nxt;
					m_copy = 1'b0;
				end
			end
			else if (ckpt_restore)
				m_ckpt = ckpt_restore_id;
			else if (ckpt_save) begin
				m_busy_cnt = NUM_AREG;
				m_copy = 1'b1;
			end
		end
	end

	// ==================================================
	// Output checks against the model
	// ==================================================

	task automatic report_mismatch(input string what, input int expv, input int actv);
		$display("ERR %s %s expected %0d actual %0d", test_name, what, expv, actv);
		$display("Result: FAILED");
		$fatal(1, "DUT output differs from the reference model");
	endtask

	assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
		else report_mismatch("busy", int'($sampled(exp_busy)), int'($sampled(busy)));
	assert property (@(posedge clk) disable iff (rst) ckpt_cur == exp_ckpt)
		else report_mismatch("ckpt_cur", int'($sampled(exp_ckpt)), int'($sampled(ckpt_cur)));
	assert property (@(posedge clk) disable iff (rst) ren_accept == exp_accept)
		else report_mismatch("accept", int'($sampled(exp_accept)), int'($sampled(ren_accept)));
	assert property (@(posedge clk) disable iff (rst) exp_accept |-> ren_psrc_a0 == exp_psrc_a0)
		else report_mismatch("psrc_a0", int'($sampled(exp_psrc_a0)), int'($sampled(ren_psrc_a0)));
	assert property (@(posedge clk) disable iff (rst) exp_accept |-> ren_psrc_b0 == exp_psrc_b0)
		else report_mismatch("psrc_b0", int'($sampled(exp_psrc_b0)), int'($sampled(ren_psrc_b0)));
	assert property (@(posedge clk) disable iff (rst) exp_accept |-> ren_psrc_a1 == exp_psrc_a1)
		else report_mismatch("psrc_a1", int'($sampled(exp_psrc_a1)), int'($sampled(ren_psrc_a1)));
	assert property (@(posedge clk) disable iff (rst) exp_accept |-> ren_psrc_b1 == exp_psrc_b1)
		else report_mismatch("psrc_b1", int'($sampled(exp_psrc_b1)), int'($sampled(ren_psrc_b1)));
	assert property (@(posedge clk) disable iff (rst)
		(exp_accept && ren_has_dst0) |-> ren_pdst0 == exp_pdst0)
		else report_mismatch("pdst0", int'($sampled(exp_pdst0)), int'($sampled(ren_pdst0)));
	assert property (@(posedge clk) disable iff (rst)
		(exp_accept && ren_has_dst1) |-> ren_pdst1 == exp_pdst1)
		else report_mismatch("pdst1", int'($sampled(exp_pdst1)), int'($sampled(ren_pdst1)));

	// ==================================================
	// Stimulus
	// ==================================================

	// Every cycle starts on the falling edge with all strobes low
	task automatic begin_cycle();
		@(negedge clk);
		ren_valid = 1'b0;
		rel_valid = 1'b0;
		ckpt_save = 1'b0;
		ckpt_restore = 1'b0;
	endtask

	task automatic idle_cycle();
		begin_cycle();
		predict();
	endtask

	task automatic wait_idle();
		idle_cycle();
		while (busy)
			idle_cycle();
	endtask

	task automatic rename_group(input int a0, b0, a1, b1, d0, d1, h0, h1);
		begin_cycle();
		ren_valid = 1'b1;
		ren_src_a0 = aregno_t'(a0);
		ren_src_b0 = aregno_t'(b0);
		ren_src_a1 = aregno_t'(a1);
		ren_src_b1 = aregno_t'(b1);
		ren_dst0 = aregno_t'(d0);
		ren_dst1 = aregno_t'(d1);
		ren_has_dst0 = 1'(h0);
		ren_has_dst1 = 1'(h1);
		predict();
	endtask

	task automatic release_oldest();
		begin_cycle();
		rel_valid = 1'b1;
		rel_preg = inflight_q[0];
		predict();
	endtask

	task automatic save_ckpt();
		begin_cycle();
		ckpt_save = 1'b1;
		predict();
		wait_idle();
	endtask

	task automatic restore_ckpt(input int id);
		begin_cycle();
		ckpt_restore = 1'b1;
		ckpt_restore_id = ckpt_ndx_t'(id);
		predict();
	endtask

	// Restores only target checkpoints that already hold a full map
	task automatic random_cycle();
		ckpt_ndx_t rid;
		begin_cycle();
		ren_valid = 1'(take_bits(1));
		ren_src_a0 = aregno_t'(take_bits(5));
		ren_src_b0 = aregno_t'(take_bits(5));
		ren_src_a1 = aregno_t'(take_bits(5));
		ren_src_b1 = aregno_t'(take_bits(5));
		ren_dst0 = aregno_t'(take_bits(5));
		ren_dst1 = aregno_t'(take_bits(5));
		ren_has_dst0 = 1'(take_bits(1));
		ren_has_dst1 = 1'(take_bits(1));
		if (1'(take_bits(1)) && inflight_q.size() > 0) begin
			rel_valid = 1'b1;
			rel_preg = inflight_q[0];
		end
		ckpt_save = (take_bits(4) == 32'd0);
		rid = ckpt_ndx_t'(take_bits(2));
		ckpt_restore = (take_bits(4) == 32'd1);
		ckpt_restore_id = ckpt_valid[rid] ? rid : ckpt_ndx_t'(0);
		predict();
	endtask

	initial begin
		lfsr_state = 32'hccba_ccd6;
		test_name = "reset";
		rst = 1'b1;
		{ren_valid, ren_has_dst0, ren_has_dst1, rel_valid, ckpt_save, ckpt_restore} = '0;
		{ren_src_a0, ren_src_b0, ren_src_a1, ren_src_b1, ren_dst0, ren_dst1} = '0;
		rel_preg = '0;
		ckpt_restore_id = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		predict();
		wait_idle();
		// Every register read once after the sweep
		test_name = "identity";
		for (int k = 0; k < NUM_AREG; k += 4)
			rename_group(k, k + 1, k + 2, k + 3, 0, 0, 0, 0);
		test_name = "alloc_order";
		for (int k = 0; k < 4; k++)
			rename_group(k, k + 4, k, k + 4, k, k + 4, 1, 1);
		rename_group(0, 1, 4, 5, 0, 0, 0, 0);
		// Same destination twice, then a lone instruction 1 writer
		test_name = "bypass";
		rename_group(9, 9, 9, 10, 9, 9, 1, 1);
		rename_group(9, 10, 7, 7, 0, 7, 0, 1);
		rename_group(9, 7, 9, 7, 0, 0, 0, 0);
		test_name = "checkpoint";
		save_ckpt();
		rename_group(3, 4, 3, 4, 3, 4, 1, 1);
		restore_ckpt(0);
		rename_group(3, 4, 9, 7, 0, 0, 0, 0);
		restore_ckpt(1);
		rename_group(3, 4, 9, 7, 0, 0, 0, 0);
		// Drain the free list, get turned away, then refill by release
		test_name = "exhaust";
		while (free_q.size() >= 2)
			rename_group(1, 2, 3, 4, 11, 12, 1, 1);
		rename_group(1, 2, 3, 4, 11, 12, 1, 1);
		repeat (3) release_oldest();
		idle_cycle();
		repeat (2) rename_group(11, 12, 11, 12, 11, 12, 1, 1);
		test_name = "random";
		repeat (RAND_CYCLES) random_cycle();
		idle_cycle();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
